// File: Makefile
# Verilator simulation of the housekeeping timer block

VERILATOR ?= verilator
TOP       ?= housekeepTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/housekeepTb.sv
`timescale 1ns/1ps
`default_nettype none

module housekeepTb;

	localparam int RefreshPeriod = 11;
	localparam int UrgentLead    = 2;
	localparam int LongWidth     = 3;  // long period of 8 wraps keeps startup short
	localparam int QosWait       = 16;
	localparam int QosWindow     = 3;
	localparam int MaxSteps      = 64;
	localparam int MinGap        = 4;  // shortest E half period in clocks
	localparam int GapSpread     = 5;  // half period is MinGap .. MinGap+GapSpread-1

	logic CLK;
	logic reset;
	logic eClk;
	logic nmiN;
	logic busActive;
	logic sndWrite;
	logic refReq;
	logic refUrg;
	logic nResOut;
	logic aoutOE;
	logic nBrIob;
	logic qosReady;

	int         opList  [MaxSteps];
	int         argList [MaxSteps];
	logic [5:0] expList [MaxSteps]; // refReq refUrg nResOut aoutOE nBrIob qosReady
	int         stepCount;
	int         errorCount;
	int         cycleCount = 0;
	int         cycleLimit = 0;     // 0 until the vectors are loaded
	int         riseClocks;         // clocks since busActive rose
	logic       startedReady;       // cycle expected to start ready

	housekeepTop #(
		.RefreshPeriod(RefreshPeriod), .UrgentLead(UrgentLead), .LongWidth(LongWidth),
		.QosWait(QosWait), .QosWindow(QosWindow)
	) u_dut (
		.CLK(CLK), .reset(reset), .eClk(eClk), .nmiN(nmiN),
		.busActive(busActive), .sndWrite(sndWrite),
		.refReq(refReq), .refUrg(refUrg), .nResOut(nResOut),
		.aoutOE(aoutOE), .nBrIob(nBrIob), .qosReady(qosReady)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK; // 4 ns period
	end

	// watchdog over the whole run
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("timeout: the run was still going after %0d clocks", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	// inputs change and outputs are read 1 ns after the edge
	task automatic waitClocks(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic checkBit(input int step, input string name, input logic got,
			input logic want);
		if (got !== want) begin
			errorCount++;
			$display("Fail time %0t step %0d: %s is %b, expected %b",
				$time, step, name, got, want);
		end
	endtask

	task automatic checkOutputs(input int step);
		logic [5:0] want;
		want = expList[step];
		checkBit(step, "refReq", refReq, want[5]);
		checkBit(step, "refUrg", refUrg, want[4]);
		checkBit(step, "nResOut", nResOut, want[3]);
		checkBit(step, "aoutOE", aoutOE, want[2]);
		checkBit(step, "nBrIob", nBrIob, want[1]);
		checkBit(step, "qosReady", qosReady, want[0]);
	endtask

	task automatic loadVectors();
		int fd;
		int fields;
		int tOp, tArg;
		int tReq, tUrg, tRes, tOe, tBr, tRdy;
		logic [8*100-1:0] lineBuf;
		fd = $fopen("bench/housekeepVectors.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("could not open bench/housekeepVectors.txt");
		end else begin
			while ($fgets(lineBuf, fd) != 0) begin
				fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h",
					tOp, tArg, tReq, tUrg, tRes, tOe, tBr, tRdy);
				if (fields == 8 && stepCount < MaxSteps) begin // comment lines give 0
					opList[stepCount]  = tOp;
					argList[stepCount] = tArg;
					expList[stepCount] = {tReq[0], tUrg[0], tRes[0], tOe[0], tBr[0], tRdy[0]};
					stepCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	// worst case clocks one step can take
	function automatic int stepCost(input int op, input int arg);
		case (op)
			1: stepCost = arg * 2 * (MinGap + GapSpread - 1);
			2: stepCost = 4;
			3: stepCost = 1;
			4: stepCost = 2 * QosWait + 8;
			5: stepCost = 12;
			default: stepCost = 1;
		endcase
	endfunction

	task automatic runPeriods(input int n);
		int gap;
		repeat (n) begin
			gap  = MinGap + int'($urandom % GapSpread);
			eClk = 1'b1;
			waitClocks(gap);
			gap  = MinGap + int'($urandom % GapSpread);
			eClk = 1'b0; // falling edge, seen two or three clocks later
			waitClocks(gap);
		end
	endtask

	task automatic startCycle(input int withWrite, input logic wantReady);
		busActive    = 1'b1;
		sndWrite     = withWrite[0];
		waitClocks(1);
		riseClocks   = 1;
		startedReady = wantReady;
	endtask

	task automatic endCycle(input int step);
		if (startedReady) begin
			// a ready cycle must stay ready for at least a full stall length
			while (riseClocks < QosWait + 1) begin
				waitClocks(1);
				riseClocks++;
				checkBit(step, "qosReady", qosReady, 1'b1);
			end
		end else begin
			while (qosReady !== 1'b1 && riseClocks < 2 * QosWait + 4) begin
				waitClocks(1);
				riseClocks++;
			end
			if (qosReady !== 1'b1) begin
				errorCount++;
				$display("step %0d: qosReady stayed low, the stall never ended", step);
			end else if (riseClocks != QosWait + 1) begin
				errorCount++;
				$display("Fail time %0t step %0d: stall length is %0d clocks, expected %0d",
					$time, step, riseClocks, QosWait + 1);
			end
		end
		busActive = 1'b0;
		sndWrite  = 1'b0;
		waitClocks(3);
	endtask

	initial begin
		int limitSum;
		void'($urandom(64235));
		reset        = 1'b1;
		eClk         = 1'b0;
		nmiN         = 1'b1;
		busActive    = 1'b0;
		sndWrite     = 1'b0;
		errorCount   = 0;
		stepCount    = 0;
		riseClocks   = 0;
		startedReady = 1'b1;
		limitSum     = 30; // initial reset and settle
		loadVectors();
		if (stepCount == 0) begin
			errorCount++;
			$display("no steps were read from the vector file");
		end
		for (int i = 0; i < stepCount; i++) begin
			limitSum += stepCost(opList[i], argList[i]);
		end
		cycleLimit = 2 * limitSum + 200;
		waitClocks(10);
		reset = 1'b0;
		waitClocks(2);
		for (int i = 0; i < stepCount; i++) begin
			case (opList[i])
				1: runPeriods(argList[i]);
				2: begin
					nmiN = argList[i][0];
					waitClocks(4); // one sync flop plus the FSM
				end
				3: startCycle(argList[i], expList[i][0]);
				4: endCycle(i);
				5: begin
					reset = 1'b1;
					waitClocks(10);
					reset = 1'b0;
					waitClocks(2);
				end
				default: begin
					errorCount++;
					$display("step %0d: unknown operation code %0d", i, opList[i]);
				end
			endcase
			checkOutputs(i);
		end
		$display("closing: %0d steps run, %0d errors", stepCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/housekeepVectors.txt
# one step per line, hex fields: op arg refReq refUrg nResOut aoutOE nBrIob qosReady
# op 1 run arg E periods, 2 set nmiN to arg, 3 start bus cycle with sndWrite arg,
# op 4 end bus cycle, 5 pulse reset
# reset values
2 01 0 0 0 0 0 1
1 00 0 0 0 0 0 1
# refresh pattern over 33 E periods, low on falls 11 22 33
1 08 1 0 0 0 0 1
1 01 1 1 0 0 0 1
1 01 1 1 0 0 0 1
1 01 0 0 0 0 0 1
1 01 1 0 0 0 0 1
1 0a 0 0 0 0 0 1
1 09 1 1 0 0 0 1
1 02 0 0 0 0 0 1
# startup with the NMI released, long counts at wraps 8 16 24
1 37 0 0 0 0 0 1
1 58 0 0 0 1 0 1
1 57 1 1 0 1 0 1
1 01 0 0 1 1 0 1
# sound write opens the window, the next cycle stalls
3 01 0 0 1 1 0 1
4 00 0 0 1 1 0 0
3 00 0 0 1 1 0 0
4 00 0 0 1 1 0 0
# window closed after 3 more wraps
1 21 0 0 1 1 0 1
3 00 0 0 1 1 0 1
4 00 0 0 1 1 0 1
# startup with the NMI held during arbitrate
5 00 0 0 0 0 0 1
1 58 0 0 0 0 0 1
2 00 0 0 0 0 1 1
1 58 0 0 0 0 1 1
2 01 0 0 0 0 1 1
1 58 0 0 0 0 1 1
1 58 0 0 1 0 1 1

// File: filelist.f
verilog/housekeepPkg.sv
verilog/refreshTimer.sv
verilog/longTimer.sv
verilog/soundQos.sv
verilog/startupSequencer.sv
verilog/housekeepTop.sv
bench/housekeepTb.sv

// File: verilog/housekeepPkg.sv
`default_nettype none

package housekeepPkg;

	// startup sequencer states, in the order they are walked through
	typedef enum logic [1:0] {
		holdReset = 2'd0, // host held in reset, bus requested
		arbitrate = 2'd1, // watch the NMI button, maybe drop the request
		driveBus  = 2'd2, // enable address outputs if the bus is ours
		running   = 2'd3  // reset released, stays here
	} initState;

	// single-cycle timing pulses shared by the datapath blocks
	typedef struct packed {
		logic eFall;   // synchronised E falling edge
		logic refWrap; // E edge on which the refresh timer wraps
		logic longTC;  // refWrap that is also the long terminal count
	} tickBus;

	// registered control outputs of the startup sequencer
	typedef struct packed {
		logic nResOut; // host reset, active low
		logic aoutOE;  // PDS address and control output enable
		logic nBrIob;  // bus request, active low
	} busCtl;

	// power-on value of the control outputs
	localparam busCtl CtlReset = '{nResOut: 1'b0, aoutOE: 1'b0, nBrIob: 1'b0};

endpackage

`default_nettype wire

// File: verilog/housekeepTop.sv
`timescale 1ns/1ps
`default_nettype none

module housekeepTop #(
	parameter int RefreshPeriod = 11, // E edges per refresh cycle
	parameter int UrgentLead    = 2,  // urgent positions before the wrap
	parameter int LongWidth     = 12, // long timer width
	parameter int QosWait       = 16, // sound stall in clocks
	parameter int QosWindow     = 3   // refresh wraps of sound window
) (
	input  wire logic CLK,
	input  wire logic reset,
	input  wire logic eClk,
	input  wire logic nmiN,
	input  wire logic busActive,
	input  wire logic sndWrite,
	output logic      refReq,
	output logic      refUrg,
	output logic      nResOut,
	output logic      aoutOE,
	output logic      nBrIob,
	output logic      qosReady
);

	housekeepPkg::tickBus refTicks;  // eFall and refWrap only
	housekeepPkg::tickBus longTicks; // with longTC added
	housekeepPkg::busCtl  ctl;

	refreshTimer #(.RefreshPeriod(RefreshPeriod), .UrgentLead(UrgentLead)) u_refresh (
		.CLK(CLK), .reset(reset), .eClk(eClk),
		.ticks(refTicks), .refReq(refReq), .refUrg(refUrg)
	);

	longTimer #(.LongWidth(LongWidth)) u_long (
		.CLK(CLK), .reset(reset), .ticksIn(refTicks), .ticksOut(longTicks)
	);

	startupSequencer u_startup (
		.CLK(CLK), .reset(reset), .nmiN(nmiN), .ticks(longTicks), .ctl(ctl)
	);

	soundQos #(.QosWait(QosWait), .QosWindow(QosWindow)) u_qos (
		.CLK(CLK), .reset(reset), .busActive(busActive), .sndWrite(sndWrite),
		.ticks(longTicks), .qosReady(qosReady)
	);

	// control struct out to the pins
	assign nResOut = ctl.nResOut;
	assign aoutOE  = ctl.aoutOE;
	assign nBrIob  = ctl.nBrIob;

endmodule

`default_nettype wire

// File: verilog/longTimer.sv
`timescale 1ns/1ps
`default_nettype none

module longTimer #(
	parameter int LongWidth = 12 // 2^LongWidth refresh wraps per long period
) (
	input  wire logic             CLK,
	input  wire logic             reset,
	input  housekeepPkg::tickBus  ticksIn,
	output housekeepPkg::tickBus  ticksOut
);

	// one below all ones, the flag is then ready for the final wrap
	localparam logic [LongWidth-1:0] PreTerm = {{(LongWidth-1){1'b1}}, 1'b0};

	logic [LongWidth-1:0] longCount;
	logic                 termFlag; // count is at its last value

	always_ff @(posedge CLK) begin
		if (reset) begin
			longCount <= '0;
			termFlag  <= 1'b0;
		end else if (ticksIn.refWrap) begin
			longCount <= longCount + 1'b1; // rolls over on its own
			termFlag  <= longCount == PreTerm; // look-ahead, saves a wide compare
		end
	end

	// pass the edge pulses through and attach the terminal count
	always_comb begin
		ticksOut        = ticksIn;
		ticksOut.longTC = ticksIn.refWrap && termFlag;
	end

endmodule

`default_nettype wire

// File: verilog/refreshTimer.sv
`timescale 1ns/1ps
`default_nettype none

module refreshTimer #(
	parameter int RefreshPeriod = 11, // E edges per refresh cycle
	parameter int UrgentLead    = 2   // urgent positions ahead of the wrap
) (
	input  wire logic             CLK,
	input  wire logic             reset,
	input  wire logic             eClk,    // slow E clock from the host bus
	output housekeepPkg::tickBus  ticks,
	output logic                  refReq,
	output logic                  refUrg
);

	localparam int CountWidth = $clog2(RefreshPeriod);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(RefreshPeriod - 1);
	localparam logic [CountWidth-1:0] PreLast   = CountWidth'(RefreshPeriod - 2);
	localparam logic [CountWidth-1:0] UrgStart  = CountWidth'(RefreshPeriod - 1 - UrgentLead);

	logic [2:0]            eSync;    // [0] first flop, [1] second flop, [2] edge history
	logic                  eFall;
	logic [CountWidth-1:0] refCount; // position within the refresh cycle
	logic                  timerTC;  // set one position before the wrap

	// two-flop synchroniser, E is asynchronous to CLK
	always_ff @(posedge CLK) begin
		if (reset) begin
			eSync <= 3'b000; // low so a high E at startup is not a fall
		end else begin
			eSync <= {eSync[1:0], eClk};
		end
	end

	assign eFall = eSync[2] && !eSync[1]; // was high, now low

	// refresh counter only moves on E falling edges
	always_ff @(posedge CLK) begin
		if (reset) begin
			refCount <= '0;
			timerTC  <= 1'b0;
			refReq   <= 1'b0;
			refUrg   <= 1'b0;
		end else if (eFall) begin
			if (timerTC) begin
				refCount <= '0; // wrap
			end else begin
				refCount <= refCount + 1'b1;
			end
			// outputs follow the count before this edge
			refReq  <= refCount != LastCount;
			refUrg  <= (refCount >= UrgStart) && (refCount < LastCount);
			timerTC <= refCount == PreLast;
		end
	end

	// pulses seen by the rest of the block in the same cycle as the edge
	assign ticks.eFall   = eFall;
	assign ticks.refWrap = eFall && timerTC;
	assign ticks.longTC  = 1'b0; // added downstream by the long timer

endmodule

`default_nettype wire

// File: verilog/soundQos.sv
`timescale 1ns/1ps
`default_nettype none

module soundQos #(
	parameter int QosWait   = 16, // stall length in clocks
	parameter int QosWindow = 3   // refresh wraps the window stays open
) (
	input  wire logic             CLK,
	input  wire logic             reset,
	input  wire logic             busActive, // bus master cycle in progress
	input  wire logic             sndWrite,  // cycle is a sound RAM write
	input  housekeepPkg::tickBus  ticks,
	output logic                  qosReady   // low holds the current cycle
);

	localparam int WinWidth  = $clog2(QosWindow + 1);
	localparam int WaitWidth = $clog2(QosWait + 1);
	localparam logic [WinWidth-1:0]  WinLoad  = WinWidth'(QosWindow);
	localparam logic [WaitWidth-1:0] WaitLast = WaitWidth'(QosWait);

	logic [WinWidth-1:0]  winCount;  // wraps left before the window closes
	logic [WaitWidth-1:0] waitCount; // clocks since busActive rose
	logic                 winOpen;

	assign winOpen = winCount != '0;

	// window opens on a sound write, then runs down on refresh wraps
	always_ff @(posedge CLK) begin
		if (reset) begin
			winCount <= '0;
		end else if (busActive && sndWrite) begin
			winCount <= WinLoad; // a new write restarts the window
		end else if (winOpen && ticks.refWrap) begin
			winCount <= winCount - 1'b1;
		end
	end

	// stall counter, cleared between cycles
	always_ff @(posedge CLK) begin
		if (reset) begin
			waitCount <= '0;
		end else if (!busActive) begin
			waitCount <= '0;
		end else if (waitCount != WaitLast) begin
			waitCount <= waitCount + 1'b1; // hold at the end of the stall
		end
	end

	// readiness is only re-evaluated between cycles or while stalled,
	// so a cycle that started ready is never pulled back
	always_ff @(posedge CLK) begin
		if (reset) begin
			qosReady <= 1'b1;
		end else if (!busActive || !qosReady) begin
			qosReady <= !winOpen || (waitCount == WaitLast);
		end
	end

endmodule

`default_nettype wire

// File: verilog/startupSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module startupSequencer (
	input  wire logic             CLK,
	input  wire logic             reset,
	input  wire logic             nmiN,  // NMI button, active low, asynchronous
	input  housekeepPkg::tickBus  ticks,
	output housekeepPkg::busCtl   ctl
);

	housekeepPkg::initState state;
	logic                   nmiSync; // button after one flop
	logic                   stepTC;  // long terminal count, advances the FSM

	assign stepTC = ticks.longTC;

	// button is slow, one flop is enough
	always_ff @(posedge CLK) begin
		if (reset) begin
			nmiSync <= 1'b1; // released
		end else begin
			nmiSync <= nmiN;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= housekeepPkg::holdReset;
			ctl   <= housekeepPkg::CtlReset;
		end else begin
			case (state)
				housekeepPkg::holdReset: begin
					ctl.aoutOE  <= 1'b0; // PDS address and control tristated
					ctl.nResOut <= 1'b0; // host kept in reset
					ctl.nBrIob  <= 1'b0; // ask for the bus by default
					if (stepTC) begin
						state <= housekeepPkg::arbitrate;
					end
				end
				housekeepPkg::arbitrate: begin
					ctl.aoutOE  <= 1'b0;
					ctl.nResOut <= 1'b0;
					// NMI held means leave the bus alone, never ask again
					ctl.nBrIob  <= ctl.nBrIob || !nmiSync;
					if (stepTC && nmiSync) begin
						state <= housekeepPkg::driveBus; // wait for release
					end
				end
				housekeepPkg::driveBus: begin
					ctl.aoutOE  <= !ctl.nBrIob; // drive only if still requesting
					ctl.nResOut <= 1'b0;
					if (stepTC) begin
						state <= housekeepPkg::running;
					end
				end
				housekeepPkg::running: begin
					ctl.nResOut <= 1'b1; // let the host run
				end
				default: begin
					state <= housekeepPkg::holdReset;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
